// ==== Bender.yml ====
package:
  name: updi_id_reader

sources:
  - files:
      - rtl/updi_pkg.sv
      - rtl/updi_frame_tx.sv
      - rtl/updi_rx_collector.sv
      - rtl/updi_id_sequencer.sv
      - rtl/updi_id_reader.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/updi_id_reader_sva.sv
      - verif/updi_id_reader_tb.sv

// ==== filelist.f ====
rtl/updi_pkg.sv
rtl/updi_frame_tx.sv
rtl/updi_rx_collector.sv
rtl/updi_id_sequencer.sv
rtl/updi_id_reader.sv
verif/tb_clock.sv
verif/updi_id_reader_sva.sv
verif/updi_id_reader_tb.sv

// ==== rtl/updi_frame_tx.sv ====
// writes one fixed UPDI frame per cmd_start; cmd_start must only come while no frame is in flight
`default_nettype none

module updi_frame_tx (
	input logic clk,
	input logic rst,

	input logic cmd_start,
	input updi_pkg::cmd_t cmd_kind,
	output logic tx_done,

	output updi_pkg::byte_t uart_tx_data,
	output logic uart_tx_wr_en,
	input logic uart_tx_full
);

	import updi_pkg::*;

	logic active;
	cmd_t kind_q;
	logic [1:0] byte_idx;
	logic wr;

	// hold the current byte while the FIFO is full
	assign wr = active && !uart_tx_full;
	assign uart_tx_wr_en = wr;
	assign uart_tx_data = frame_byte(kind_q, byte_idx);

	// done in the same cycle the last byte enters the FIFO
	assign tx_done = wr && (byte_idx == frame_last(kind_q));

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			byte_idx <= 2'd0;
		end
		else if (cmd_start) begin
			active <= 1'b1;
			byte_idx <= 2'd0;
		end
		else if (wr) begin
			if (tx_done) begin
				active <= 1'b0;
				byte_idx <= 2'd0;
			end
			else begin
				byte_idx <= byte_idx + 2'd1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cmd_start) begin
			kind_q <= cmd_kind;
		end
	end

endmodule

`default_nettype wire

// ==== rtl/updi_id_reader.sv ====
// UPDI device-ID reader top; needs an external UART with TX/RX FIFOs and a double-break generator
`default_nettype none

module updi_id_reader #(
	parameter int TIMEOUT_CLKS = 1000
) (
	input logic clk,
	input logic rst,

	input logic start,
	output logic busy,
	output logic done,
	output logic fail,
	output updi_pkg::device_id_t device_id,
	input logic phy_error,

	output updi_pkg::byte_t uart_tx_data,
	output logic uart_tx_wr_en,
	input logic uart_tx_full,

	input updi_pkg::byte_t uart_rx_data,
	output logic uart_rx_rd_en,
	input logic uart_rx_empty,

	output logic double_break_start,
	input logic double_break_done
);

	import updi_pkg::*;

	logic cmd_start;
	cmd_t cmd_kind;
	logic tx_done;
	logic rx_start;
	rx_count_t rx_count;
	logic rx_done;
	logic rx_timeout;
	device_id_t rx_data;

	updi_id_sequencer seq_inst (
		.clk(clk),
		.rst(rst),
		.start(start),
		.phy_error(phy_error),
		.busy(busy),
		.done(done),
		.fail(fail),
		.device_id(device_id),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done),
		.cmd_start(cmd_start),
		.cmd_kind(cmd_kind),
		.rx_start(rx_start),
		.rx_count(rx_count),
		.tx_done(tx_done),
		.rx_done(rx_done),
		.rx_timeout(rx_timeout),
		.rx_data(rx_data)
	);

	updi_frame_tx tx_inst (
		.clk(clk),
		.rst(rst),
		.cmd_start(cmd_start),
		.cmd_kind(cmd_kind),
		.tx_done(tx_done),
		.uart_tx_data(uart_tx_data),
		.uart_tx_wr_en(uart_tx_wr_en),
		.uart_tx_full(uart_tx_full)
	);

	// runs alongside the transmitter, started together with each reading frame
	updi_rx_collector #(
		.TIMEOUT_CLKS(TIMEOUT_CLKS)
	) rx_inst (
		.clk(clk),
		.rst(rst),
		.rx_start(rx_start),
		.rx_count(rx_count),
		.rx_done(rx_done),
		.rx_timeout(rx_timeout),
		.rx_data(rx_data),
		.uart_rx_data(uart_rx_data),
		.uart_rx_rd_en(uart_rx_rd_en),
		.uart_rx_empty(uart_rx_empty)
	);

endmodule

`default_nettype wire

// ==== rtl/updi_id_sequencer.sv ====
// fixed UPDI ID-read session; any error ends the run with fail, there is no retry
`default_nettype none

module updi_id_sequencer (
	input logic clk,
	input logic rst,

	input logic start,
	input logic phy_error,
	output logic busy,
	output logic done,
	output logic fail,
	output updi_pkg::device_id_t device_id,

	output logic double_break_start,
	input logic double_break_done,

	output logic cmd_start,
	output updi_pkg::cmd_t cmd_kind,
	output logic rx_start,
	output updi_pkg::rx_count_t rx_count,
	input logic tx_done,
	input logic rx_done,
	input logic rx_timeout,
	input updi_pkg::device_id_t rx_data
);

	import updi_pkg::*;

	typedef enum logic [3:0] {
		S_IDLE,
		S_DB_START,
		S_DB_WAIT,
		S_STATUS_CMD,
		S_STATUS_WAIT,
		S_PTR_CMD,
		S_PTR_WAIT,
		S_REPEAT_CMD,
		S_REPEAT_WAIT,
		S_LD_CMD,
		S_LD_WAIT,
		S_DONE,
		S_FAIL
	} seq_state_t;

	seq_state_t state;
	logic tx_pending;
	logic rx_pending;
	logic db_seen;
	logic tx_clear;
	logic step_ok;
	logic running;

	// a step is complete once its frame is out and its response (if any) is in
	assign tx_clear = !tx_pending || tx_done;
	assign step_ok = tx_clear && (!rx_pending || rx_done);
	assign running = busy && !done && !fail;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= S_IDLE;
			tx_pending <= 1'b0;
			rx_pending <= 1'b0;
			db_seen <= 1'b0;
			device_id <= '0;
		end
		else begin
			// kept across a failed run so a new session never starts mid-frame
			if (cmd_start) begin
				tx_pending <= 1'b1;
			end
			else if (tx_done) begin
				tx_pending <= 1'b0;
			end

			if (rx_start) begin
				rx_pending <= 1'b1;
			end
			else if (rx_done || rx_timeout) begin
				rx_pending <= 1'b0;
			end

			if (state == S_IDLE) begin
				db_seen <= 1'b0;
			end
			else if (double_break_done) begin
				db_seen <= 1'b1;
			end

			if (running && phy_error) begin
				state <= S_FAIL;
			end
			else begin
				case (state)
					S_IDLE: begin
						if (start) begin
							state <= S_DB_START;
						end
					end
					S_DB_START: state <= S_DB_WAIT;
					S_DB_WAIT: begin
						if ((db_seen || double_break_done) && tx_clear) begin
							state <= S_STATUS_CMD;
						end
					end
					S_STATUS_CMD: state <= S_STATUS_WAIT;
					S_STATUS_WAIT: begin
						// STATUSA reads zero when the UPDI link is not up
						if (rx_timeout) begin
							state <= S_FAIL;
						end
						else if (step_ok) begin
							state <= (rx_data[7:0] != 8'h00) ? S_PTR_CMD : S_FAIL;
						end
					end
					S_PTR_CMD: state <= S_PTR_WAIT;
					S_PTR_WAIT: begin
						if (rx_timeout) begin
							state <= S_FAIL;
						end
						else if (step_ok) begin
							state <= (rx_data[7:0] == UPDI_ACK) ? S_REPEAT_CMD : S_FAIL;
						end
					end
					S_REPEAT_CMD: state <= S_REPEAT_WAIT;
					S_REPEAT_WAIT: begin
						if (step_ok) begin
							state <= S_LD_CMD;
						end
					end
					S_LD_CMD: state <= S_LD_WAIT;
					S_LD_WAIT: begin
						if (rx_timeout) begin
							state <= S_FAIL;
						end
						else if (step_ok) begin
							device_id <= rx_data;
							state <= S_DONE;
						end
					end
					default: state <= S_IDLE;
				endcase
			end
		end
	end

	always_comb begin
		busy = (state != S_IDLE);
		done = (state == S_DONE);
		fail = (state == S_FAIL);
		double_break_start = (state == S_DB_START);

		cmd_start = 1'b0;
		cmd_kind = CMD_LDCS_STATUS;
		rx_start = 1'b0;
		rx_count = 2'd1;

		case (state)
			S_STATUS_CMD: begin
				cmd_start = 1'b1;
				rx_start = 1'b1;
			end
			S_PTR_CMD: begin
				// device answers the address bytes with a single ACK
				cmd_start = 1'b1;
				cmd_kind = CMD_ST_PTR_SIG;
				rx_start = 1'b1;
			end
			S_REPEAT_CMD: begin
				cmd_start = 1'b1;
				cmd_kind = CMD_REPEAT_ID;
			end
			S_LD_CMD: begin
				// repeat count plus one signature bytes come back
				cmd_start = 1'b1;
				cmd_kind = CMD_LD_PTR_INC;
				rx_start = 1'b1;
				rx_count = rx_count_t'(ID_REPEAT_COUNT + 8'd1);
			end
			default: begin
				cmd_start = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== rtl/updi_pkg.sv ====
// shared UPDI types and frame tables; covers only the ID-read session (LDCS, ST ptr, REPEAT, LD)
`default_nettype none

package updi_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [23:0] device_id_t;
	typedef logic [1:0] rx_count_t;

	typedef enum logic [1:0] {
		CMD_LDCS_STATUS,
		CMD_ST_PTR_SIG,
		CMD_REPEAT_ID,
		CMD_LD_PTR_INC
	} cmd_t;

	localparam byte_t UPDI_SYNC = 8'h55;
	localparam byte_t UPDI_ACK = 8'h40;
	localparam logic [15:0] SIG_BASE_ADDR = 16'h1100;
	localparam byte_t ID_REPEAT_COUNT = 8'd2;

	// opcodes: LDCS STATUSA, ST ptr (word addr), REPEAT (byte count), LD *(ptr++) byte
	localparam byte_t OP_LDCS_STATUSA = 8'h80;
	localparam byte_t OP_ST_PTR_WORD = 8'h69;
	localparam byte_t OP_REPEAT_BYTE = 8'hA0;
	localparam byte_t OP_LD_PTR_INC = 8'h24;

	// index of the last byte of each frame
	function automatic logic [1:0] frame_last(cmd_t kind);
		case (kind)
			CMD_ST_PTR_SIG: return 2'd3;
			CMD_REPEAT_ID: return 2'd2;
			default: return 2'd1;
		endcase
	endfunction

	function automatic byte_t frame_byte(cmd_t kind, logic [1:0] idx);
		byte_t b;
		b = UPDI_SYNC;
		if (idx != 2'd0) begin
			case (kind)
				CMD_LDCS_STATUS: b = OP_LDCS_STATUSA;
				CMD_ST_PTR_SIG: begin
					// address goes out low byte first
					case (idx)
						2'd1: b = OP_ST_PTR_WORD;
						2'd2: b = SIG_BASE_ADDR[7:0];
						default: b = SIG_BASE_ADDR[15:8];
					endcase
				end
				CMD_REPEAT_ID: b = (idx == 2'd1) ? OP_REPEAT_BYTE : ID_REPEAT_COUNT;
				default: b = OP_LD_PTR_INC;
			endcase
		end
		return b;
	endfunction

endpackage

`default_nettype wire

// ==== rtl/updi_rx_collector.sv ====
// pops 1 to 3 response bytes from a show-ahead RX FIFO; a new rx_start drops any unfinished request
`default_nettype none

module updi_rx_collector #(
	parameter int TIMEOUT_CLKS = 1000
) (
	input logic clk,
	input logic rst,

	input logic rx_start,
	input updi_pkg::rx_count_t rx_count,
	output logic rx_done,
	output logic rx_timeout,
	output updi_pkg::device_id_t rx_data,

	input updi_pkg::byte_t uart_rx_data,
	output logic uart_rx_rd_en,
	input logic uart_rx_empty
);

	import updi_pkg::*;

	localparam int CNT_W = $clog2(TIMEOUT_CLKS + 1);

	logic active;
	rx_count_t remaining;
	logic [CNT_W-1:0] idle_cnt;
	logic pop;

	// no pop in the start cycle, the request is being (re)loaded
	assign pop = active && !uart_rx_empty && !rx_start;
	assign uart_rx_rd_en = pop;

	always_ff @(posedge clk) begin
		if (rst) begin
			active <= 1'b0;
			remaining <= '0;
			idle_cnt <= '0;
			rx_done <= 1'b0;
			rx_timeout <= 1'b0;
		end
		else begin
			rx_done <= 1'b0;
			rx_timeout <= 1'b0;
			if (rx_start) begin
				active <= 1'b1;
				remaining <= rx_count;
				idle_cnt <= '0;
			end
			else if (pop) begin
				remaining <= remaining - 2'd1;
				idle_cnt <= '0;
				if (remaining == 2'd1) begin
					active <= 1'b0;
					rx_done <= 1'b1;
				end
			end
			else if (active) begin
				// idle time is measured per byte, not per request
				if (idle_cnt == CNT_W'(TIMEOUT_CLKS - 1)) begin
					active <= 1'b0;
					rx_timeout <= 1'b1;
				end
				else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
		end
	end

	// earlier bytes end up more significant, unused upper bytes stay zero
	always_ff @(posedge clk) begin
		if (rx_start) begin
			rx_data <= '0;
		end
		else if (pop) begin
			rx_data <= {rx_data[15:0], uart_rx_data};
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
// free-running testbench clock; starts low, first rising edge after half a period
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(PERIOD / 2) clk = ~clk;
		end
	end

endmodule

`default_nettype wire

// ==== verif/updi_id_reader_sva.sv ====
// session protocol assertions, bound into updi_id_sequencer; inactive while rst is high
`default_nettype none

module updi_id_reader_sva (
	input logic clk,
	input logic rst,
	input logic busy,
	input logic done,
	input logic fail,
	input logic cmd_start
);

	assert property (@(posedge clk) disable iff (rst) !(done && fail))
		else $error("done and fail high in the same cycle");

	assert property (@(posedge clk) disable iff (rst) !busy |-> !cmd_start)
		else $error("cmd_start while not busy");

	// the result pulse is the last cycle of a session
	assert property (@(posedge clk) disable iff (rst) (done || fail) |=> !busy)
		else $error("busy still high after the result pulse");

	assert property (@(posedge clk) disable iff (rst) $fell(busy) |-> $past(done || fail))
		else $error("busy fell without done or fail");

endmodule

`default_nettype wire

// ==== verif/updi_id_reader_tb.sv ====
// directed tests with a no-echo UPDI device model; the DUT runs with a 200-cycle byte timeout
`default_nettype none

module updi_id_reader_tb;

	import updi_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int MAX_CYCLES = 20000;
	localparam int WAIT_LIMIT = 2000;
	localparam logic [31:0] SEED = 32'h890e_8ddc;

	logic clk;
	logic rst = 1'b1;
	logic start = 1'b0;
	logic phy_error = 1'b0;
	logic uart_tx_full = 1'b0;
	byte_t uart_rx_data = 8'h00;
	logic uart_rx_empty = 1'b1;
	logic double_break_done = 1'b0;
	logic busy;
	logic done;
	logic fail;
	logic uart_tx_wr_en;
	logic uart_rx_rd_en;
	logic double_break_start;
	byte_t uart_tx_data;
	device_id_t device_id;

	// device model state
	byte_t tx_log[$];
	byte_t frame_q[$];
	byte_t rx_q[$];
	byte_t status_byte = 8'h01;
	byte_t ack_byte = 8'h40;
	device_id_t id_bytes = '0;
	logic ld_silent = 1'b0;
	logic bp_en = 1'b0;
	int db_cnt = 0;
	int done_cnt = 0;
	int fail_cnt = 0;
	int cycle_cnt = 0;

	tb_clock #(.PERIOD(100)) clk_gen (.clk(clk));

	updi_id_reader #(
		.TIMEOUT_CLKS(TIMEOUT)
	) dut (
		.clk(clk),
		.rst(rst),
		.start(start),
		.busy(busy),
		.done(done),
		.fail(fail),
		.device_id(device_id),
		.phy_error(phy_error),
		.uart_tx_data(uart_tx_data),
		.uart_tx_wr_en(uart_tx_wr_en),
		.uart_tx_full(uart_tx_full),
		.uart_rx_data(uart_rx_data),
		.uart_rx_rd_en(uart_rx_rd_en),
		.uart_rx_empty(uart_rx_empty),
		.double_break_start(double_break_start),
		.double_break_done(double_break_done)
	);

	bind updi_id_sequencer updi_id_reader_sva sva_inst (
		.clk(clk),
		.rst(rst),
		.busy(busy),
		.done(done),
		.fail(fail),
		.cmd_start(cmd_start)
	);

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("error: %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
			$display("Result: FAILED");
			$fatal(1, "check failed");
		end
	endtask

	// total frame length, keyed by the opcode byte after SYNC
	function automatic int frame_len(byte_t opcode);
		case (opcode)
			8'h69: return 4;
			8'hA0: return 3;
			default: return 2;
		endcase
	endfunction

	task automatic answer_frame(byte_t opcode);
		case (opcode)
			8'h80: rx_q.push_back(status_byte);
			8'h69: rx_q.push_back(ack_byte);
			8'h24: begin
				if (!ld_silent) begin
					rx_q.push_back(id_bytes[23:16]);
					rx_q.push_back(id_bytes[15:8]);
					rx_q.push_back(id_bytes[7:0]);
				end
			end
			default: begin
				// REPEAT has no response
			end
		endcase
	endtask

	// show-ahead RX FIFO and frame parser of the device
	always @(posedge clk) begin
		if (uart_rx_rd_en && rx_q.size() > 0) begin
			void'(rx_q.pop_front());
		end
		if (uart_tx_wr_en) begin
			tx_log.push_back(uart_tx_data);
			frame_q.push_back(uart_tx_data);
			if (frame_q.size() == 1) begin
				check_eq(frame_q[0], UPDI_SYNC, "frame starts with SYNC");
			end
			else if (frame_q.size() == frame_len(frame_q[1])) begin
				answer_frame(frame_q[1]);
				frame_q.delete();
			end
		end
		uart_rx_empty <= (rx_q.size() == 0);
		if (rx_q.size() > 0) begin
			uart_rx_data <= rx_q[0];
		end
	end

	// double break finishes 3 cycles after the request
	always @(posedge clk) begin
		double_break_done <= 1'b0;
		if (double_break_start) begin
			db_cnt <= 3;
		end
		else if (db_cnt != 0) begin
			db_cnt <= db_cnt - 1;
			if (db_cnt == 1) begin
				double_break_done <= 1'b1;
			end
		end
	end

	always @(posedge clk) begin
		if (bp_en) begin
			uart_tx_full <= ($urandom_range(0, 1) == 1);
		end
		else begin
			uart_tx_full <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (done) begin
			done_cnt <= done_cnt + 1;
		end
		if (fail) begin
			fail_cnt <= fail_cnt + 1;
		end
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	// changed between edges, while the model is quiet
	task automatic setup_model(input byte_t status, input byte_t ack, input device_id_t id,
		input logic silent, input logic bp);
		@(negedge clk);
		tx_log.delete();
		frame_q.delete();
		rx_q.delete();
		status_byte = status;
		ack_byte = ack;
		id_bytes = id;
		ld_silent = silent;
		bp_en = bp;
	endtask

	task automatic start_session();
		@(posedge clk);
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		// busy and the double-break request both rise in the cycle after start
		@(posedge clk);
		check_eq(busy, 1'b1, "busy rises after start");
		check_eq(double_break_start, 1'b1, "double_break_start in first busy cycle");
	endtask

	// returns in the cycle where done or fail is high
	task automatic wait_session_end();
		int n;
		n = 0;
		@(posedge clk);
		while (!(done || fail) && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		if (!(done || fail)) begin
			$display("timeout: session ended with neither done nor fail");
			$display("Result: FAILED");
			$fatal(1, "session did not end");
		end
	endtask

	task automatic check_stream();
		byte_t exp [11];
		exp = '{UPDI_SYNC, 8'h80, UPDI_SYNC, 8'h69, SIG_BASE_ADDR[7:0], SIG_BASE_ADDR[15:8],
			UPDI_SYNC, 8'hA0, ID_REPEAT_COUNT, UPDI_SYNC, 8'h24};
		check_eq(tx_log.size(), 11, "tx byte count");
		foreach (exp[i]) begin
			check_eq(tx_log[i], exp[i], $sformatf("tx byte %0d", i));
		end
	endtask

	task automatic run_session(input logic expect_done, input string what);
		int d0;
		int f0;
		d0 = done_cnt;
		f0 = fail_cnt;
		start_session();
		wait_session_end();
		check_eq(done, expect_done, {what, ": done at end"});
		check_eq(fail, !expect_done, {what, ": fail at end"});
		@(posedge clk);
		check_eq(busy, 1'b0, {what, ": busy falls after result"});
		check_eq(done_cnt - d0, expect_done, {what, ": done pulses"});
		check_eq(fail_cnt - f0, !expect_done, {what, ": fail pulses"});
	endtask

	task automatic good_session(input logic bp, input string what);
		byte_t status;
		device_id_t id;
		status = byte_t'($urandom_range(1, 255));
		id = device_id_t'($urandom);
		setup_model(status, UPDI_ACK, id, 1'b0, bp);
		run_session(1'b1, what);
		check_eq(device_id, id, {what, ": device_id"});
		check_stream();
	endtask

	task automatic verify_reset_state();
		check_eq(busy, 1'b0, "busy after reset");
		check_eq(done, 1'b0, "done after reset");
		check_eq(fail, 1'b0, "fail after reset");
		check_eq(double_break_start, 1'b0, "double_break_start after reset");
		check_eq(uart_tx_wr_en, 1'b0, "uart_tx_wr_en after reset");
		check_eq(uart_rx_rd_en, 1'b0, "uart_rx_rd_en after reset");
		check_eq(device_id, 24'h0, "device_id after reset");
	endtask

	task automatic zero_status_session();
		device_id_t id_before;
		id_before = device_id;
		setup_model(8'h00, UPDI_ACK, device_id_t'($urandom), 1'b0, 1'b0);
		run_session(1'b0, "zero status");
		repeat (20) @(posedge clk);
		check_eq(tx_log.size(), 2, "zero status: only the LDCS frame");
		check_eq(device_id, id_before, "zero status: device_id kept");
	endtask

	task automatic missing_response_sessions();
		setup_model(8'h5a, UPDI_ACK, device_id_t'($urandom), 1'b1, 1'b0);
		run_session(1'b0, "no LD response");
		check_eq(tx_log.size(), 11, "no LD response: all frames sent");
		setup_model(8'h5a, UPDI_ACK ^ 8'h01, device_id_t'($urandom), 1'b0, 1'b0);
		run_session(1'b0, "wrong ACK");
		check_eq(tx_log.size(), 6, "wrong ACK: stops after ST frame");
	endtask

	task automatic link_error_recovery();
		int n;
		setup_model(8'h33, UPDI_ACK, device_id_t'($urandom), 1'b0, 1'b0);
		start_session();
		n = 0;
		@(posedge clk);
		while (!uart_tx_wr_en && n < WAIT_LIMIT) begin
			@(posedge clk);
			n++;
		end
		check_eq(uart_tx_wr_en, 1'b1, "link error: first frame started");
		phy_error <= 1'b1;
		@(posedge clk);
		phy_error <= 1'b0;
		wait_session_end();
		check_eq(fail, 1'b1, "link error: fail");
		@(posedge clk);
		check_eq(busy, 1'b0, "link error: busy falls");
		// let the abandoned frame and response request run out
		repeat (TIMEOUT + 50) @(posedge clk);
		good_session(1'b0, "after link error");
	endtask

	initial begin
		void'($urandom(SEED));
		repeat (8) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		verify_reset_state();
		good_session(1'b0, "normal");
		good_session(1'b1, "back-pressure");
		zero_status_session();
		missing_response_sessions();
		link_error_recovery();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire
